/* flist.f */
+incdir+verilog
verilog/pinx_pkg.sv
verilog/pinx_fifo.sv
verilog/pinx_out.sv
verilog/pinx_in.sv
verilog/pinx_loopback_top.sv
verif/tb_pinx.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the pin link testbench with Verilator, runs it and checks the log

set -u

cd "$(dirname "$0")" || exit 1

TOP=tb_pinx
OBJ_DIR=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log

# Compile the file list into a simulation binary
verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module "$TOP" --Mdir "$OBJ_DIR" -o "$TOP" \
    -f flist.f > "$BUILD_LOG" 2>&1
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status, see $BUILD_LOG"
    exit 1
fi

# Run the simulation and keep everything it prints
"./$OBJ_DIR/$TOP" > "$SIM_LOG" 2>&1
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status, see $SIM_LOG"
    exit 1
fi

# The testbench prints the pass message on a line of its own
if grep -qxF '>>> PASS' "$SIM_LOG"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see $SIM_LOG"
    exit 1
fi

/* verif/tb_pinx.sv */
`timescale 1ns/10ps

`include "pinx_cfg.svh"

module tb_pinx
    import pinx_pkg::*;
;

    // Phase lengths in words for the driven phases and in cycles for the stall
    localparam int PHASE_A_WORDS  = 200;
    localparam int STALL_CYCLES   = 40;
    localparam int RECOVER_WORDS  = 20;
    localparam int PHASE_B_WORDS  = 300;
    localparam int TOTAL_WORDS    = PHASE_A_WORDS + `PINX_RX_SLOTS + RECOVER_WORDS
                                    + PHASE_B_WORDS;
    localparam int TIMEOUT_CYCLES = (PHASE_A_WORDS + STALL_CYCLES + RECOVER_WORDS
                                    + PHASE_B_WORDS) * 4;
    // 32-bit chunks needed to fill one random bus word
    localparam int WORD_CHUNKS    = (`PINX_BUS_WIDTH + 31) / 32;

    logic      CLK;
    logic      rst_in;
    bus_word_t in_data;
    logic      in_vld;
    logic      in_rdy;
    bus_word_t out_data;
    logic      out_vld;
    logic      out_rdy;

    integer seed;
    int     cycle_cnt;

    // Reference model of the words that are inside the link
    bus_word_t exp_q [$];
    bus_word_t exp_head;
    int        exp_count;
    int        acc_total;
    int        pop_total;
    // Words accepted from the last pop edge onward
    // The credit bound applies to this count
    int        since_pop;

    // Handshakes seen half a cycle before the edge where they complete
    logic      acc_seen;
    bus_word_t acc_word;
    logic      pop_seen;

    pinx_loopback_top pinx_loopback_top_inst
    (
        .CLK      (CLK),
        .rst_in   (rst_in),
        .in_data  (in_data),
        .in_vld   (in_vld),
        .in_rdy   (in_rdy),
        .out_data (out_data),
        .out_vld  (out_vld),
        .out_rdy  (out_rdy)
    );

    always #10 CLK = ~CLK;

    // Prints the reason, then the fail message, and stops the run
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display(">>> FAIL");
        $fatal(1, "run stopped at the first failure");
    endtask

    // Builds a bus word from as many random chunks as the width needs
    task automatic random_word(output bus_word_t word);
        logic [WORD_CHUNKS*32-1:0] wide;
        int i;
        for (i = 0; i < WORD_CHUNKS; i++)
        begin
            wide[i*32 +: 32] = $random(seed);
        end
        word = wide[`PINX_BUS_WIDTH-1:0];
    endtask

    // One clock of the input bus
    // A new word is only raised when nothing is pending, so a stalled word stays put
    task automatic offer_cycle(input bit want_word, output bit took);
        if (!in_vld && want_word)
        begin
            in_vld = 1'b1;
            random_word(in_data);
        end
        @(negedge CLK);
        took = in_vld && in_rdy;
        @(posedge CLK);
        #1;
        if (took)
        begin
            in_vld = 1'b0;
        end
    endtask

    // Runs until n_words have been accepted and counts a pending word as one
    task automatic drive_words(input int n_words, input bit random_flow);
        logic [31:0] rnd;
        bit took;
        int done_cnt;
        done_cnt = 0;
        while (done_cnt < n_words)
        begin
            rnd = $random(seed);
            out_rdy = random_flow ? rnd[1] : 1'b1;
            offer_cycle(!random_flow || rnd[0], took);
            if (took)
            begin
                done_cnt++;
            end
        end
    endtask

    // Holds the output bus off while words keep being offered
    task automatic stall_output(input int n_cycles);
        bit took;
        int k;
        out_rdy = 1'b0;
        for (k = 0; k < n_cycles; k++)
        begin
            offer_cycle(1'b1, took);
        end
    endtask

    // Lets the link empty out with the output bus always ready
    task automatic drain_link();
        out_rdy = 1'b1;
        @(negedge CLK);
        while (exp_count != 0 || out_vld)
        begin
            @(negedge CLK);
        end
        @(posedge CLK);
        #1;
    endtask

    // Input and output values are stable at the falling edge
    always @(negedge CLK)
    begin
        acc_seen <= in_vld && in_rdy;
        acc_word <= in_data;
        pop_seen <= out_vld && out_rdy;
    end

    // The model moves on the rising edge where the handshakes complete
    always @(posedge CLK)
    begin
        if (pop_seen)
        begin
            if (exp_q.size() > 0)
            begin
                void'(exp_q.pop_front());
            end
            pop_total = pop_total + 1;
            since_pop = acc_seen ? 1 : 0;
        end
        else if (acc_seen)
        begin
            since_pop = since_pop + 1;
        end
        if (acc_seen)
        begin
            exp_q.push_back(acc_word);
            acc_total = acc_total + 1;
        end
        exp_count = exp_q.size();
        exp_head  = (exp_q.size() > 0) ? exp_q[0] : '0;
    end

    // Cycle limit so that a stuck handshake cannot hang the run
    always @(posedge CLK)
    begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES)
            abort_run($sformatf("Timeout after %0d cycles with %0d of %0d words delivered",
                                cycle_cnt, pop_total, TOTAL_WORDS));
    end

    // In the first cycle out of reset nothing is ready to deliver and every credit is held
    chk_reset_state: assert property (@(negedge CLK) $fell(rst_in) |-> (!out_vld && in_rdy))
        else abort_run($sformatf("** Error at %0t ns: after reset out_vld=%b in_rdy=%b",
                                 $time, out_vld, in_rdy));

    chk_no_extra: assert property (@(negedge CLK) disable iff (rst_in)
                                   (out_vld && out_rdy) |-> (exp_count > 0))
        else abort_run("A word left the link although no word was outstanding");

    chk_order: assert property (@(negedge CLK) disable iff (rst_in)
                                (out_vld && out_rdy && exp_count > 0) |-> (out_data == exp_head))
        else abort_run($sformatf("** Error at %0t ns: out_data %h, expected %h",
                                 $time, out_data, exp_head));

    chk_credit_limit: assert property (@(negedge CLK) disable iff (rst_in)
                                       (in_vld && in_rdy) |-> (since_pop < `PINX_RX_SLOTS))
        else abort_run($sformatf("** Error at %0t ns: word accepted with %0d already taken",
                                 $time, since_pop));

    // With every slot spoken for, only a pop can make room again
    chk_full_stops: assert property (@(negedge CLK) disable iff (rst_in)
                                     (since_pop >= `PINX_RX_SLOTS) |-> !in_rdy)
        else abort_run($sformatf("** Error at %0t ns: in_rdy high with %0d words unpopped",
                                 $time, since_pop));

    chk_hold_output: assert property (@(negedge CLK) disable iff (rst_in)
                                      $past(out_vld && !out_rdy) |-> (out_vld && $stable(out_data)))
        else abort_run($sformatf("** Error at %0t ns: output changed under back-pressure, %b %h",
                                 $time, out_vld, out_data));

    initial
    begin
        seed      = 32'hb58df439;
        cycle_cnt = 0;
        acc_total = 0;
        pop_total = 0;
        since_pop = 0;
        exp_count = 0;
        exp_head  = '0;
        acc_seen  = 1'b0;
        acc_word  = '0;
        pop_seen  = 1'b0;
        CLK       = 1'b0;
        rst_in    = 1'b1;
        in_data   = '0;
        in_vld    = 1'b0;
        out_rdy   = 1'b0;

        repeat (5) @(posedge CLK);
        #1;
        rst_in = 1'b0;

        // Phase A streams at full rate in both directions
        drive_words(PHASE_A_WORDS, 1'b0);
        drain_link();

        // The stall fills every receive slot
        // Recovery also picks up the word left pending by the stall
        stall_output(STALL_CYCLES);
        drive_words(RECOVER_WORDS, 1'b0);
        drain_link();

        // Phase B has gaps on the input and random back-pressure on the output
        drive_words(PHASE_B_WORDS, 1'b1);
        drain_link();

        if (exp_count == 0 && acc_total == TOTAL_WORDS && pop_total == TOTAL_WORDS)
        begin
            $display(">>> PASS");
            $finish;
        end
        else
        begin
            abort_run($sformatf("Word count wrong at the end, %0d accepted and %0d delivered of %0d",
                                acc_total, pop_total, TOTAL_WORDS));
        end
    end

endmodule

/* verilog/pinx_cfg.svh */
`ifndef PINX_CFG_SVH
`define PINX_CFG_SVH

// Build settings shared by every block of the pin link

// Width of one bus word as it travels across the pins
// Any positive width works, the pins simply carry one bit per lane
`define PINX_BUS_WIDTH 66

// Words the receiver can hold beyond its two-stage pin register
// The transmitter starts with exactly this many credits after reset
// and the receiver uses the same value as its slot limit
`define PINX_RX_SLOTS 15

// Entries in the receive FIFO
// Must be at least PINX_RX_SLOTS or the credit scheme no longer
// protects the FIFO from overflow
`define PINX_FIFO_DEPTH 16

`endif

/* verilog/pinx_fifo.sv */
`timescale 1ns/10ps

`include "pinx_cfg.svh"

module pinx_fifo
    import pinx_pkg::*;
(
    input  logic      CLK,
    input  logic      rst_in,

    input  bus_word_t din,
    input  logic      din_vld,
    output logic      din_rdy,

    output bus_word_t dout,
    output logic      dout_vld,
    input  logic      dout_rdy
);

    // Pointer width covers every entry and the count needs one more value for full
    localparam int PTR_W = (`PINX_FIFO_DEPTH > 1) ? $clog2(`PINX_FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(`PINX_FIFO_DEPTH + 1);

    // Word storage is written at the tail and read at the head
    bus_word_t mem [`PINX_FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    logic push;
    logic pop;

    // The FIFO accepts a word whenever a slot is free
    assign din_rdy = (count != CNT_W'(`PINX_FIFO_DEPTH));

    // The head entry is visible as long as anything is stored
    assign dout_vld = (count != '0);
    assign dout     = mem[rd_ptr];

    assign push = din_vld && din_rdy;
    assign pop  = dout_vld && dout_rdy;

    // A pushed word lands in the entry at the write pointer
    always_ff @(posedge CLK)
    begin
        if (push)
        begin
            mem[wr_ptr] <= din;
        end
    end

    // Pointers wrap at the last entry so depths that are not a power of two also work
    always_ff @(posedge CLK or posedge rst_in)
    begin
        if (rst_in)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (push)
            begin
                wr_ptr <= (wr_ptr == PTR_W'(`PINX_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop)
            begin
                rd_ptr <= (rd_ptr == PTR_W'(`PINX_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    // Occupancy is unchanged when a push and a pop land on the same edge
    always_ff @(posedge CLK or posedge rst_in)
    begin
        if (rst_in)
        begin
            count <= '0;
        end
        else
        begin
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* verilog/pinx_in.sv */
`timescale 1ns/10ps

`include "pinx_cfg.svh"

module pinx_in
    import pinx_pkg::*;
(
    input  logic      CLK,
    input  logic      rst_in,

    // Pin side of the link
    input  bus_word_t pinx_data,
    input  logic      pinx_vld,
    output logic      pinx_tok,

    // Bus words handed on to the receiving logic
    output bus_word_t out_data,
    output logic      out_vld,
    input  logic      out_rdy
);

    // Two register stages on the pins with index 1 nearest the pads
    bus_word_t pipe_data [2];
    logic [1:0] pipe_vld;

    // Slot count where PINX_RX_SLOTS means no tokens are owed
    credit_cnt_t slot_cnt;

    // Token shift register whose bit 0 drives the pin
    logic [1:0] tok_pipe;

    logic tok_issue;
    logic pop;

    // A token is owed for every slot freed by a pop and not yet returned
    assign tok_issue = (slot_cnt != credit_cnt_t'(`PINX_RX_SLOTS));
    assign pop       = out_vld && out_rdy;
    assign pinx_tok  = tok_pipe[0];

    // Pop and token issue move the count in opposite directions
    always_ff @(posedge CLK or posedge rst_in)
    begin
        if (rst_in)
        begin
            slot_cnt <= credit_cnt_t'(`PINX_RX_SLOTS);
        end
        else
        begin
            case ({tok_issue, pop})
                2'b10:   slot_cnt <= slot_cnt + credit_cnt_t'(1);
                2'b01:   slot_cnt <= slot_cnt - credit_cnt_t'(1);
                default: slot_cnt <= slot_cnt;
            endcase
        end
    end

    // A token issued now reaches the pin two edges later
    always_ff @(posedge CLK or posedge rst_in)
    begin
        if (rst_in)
        begin
            tok_pipe <= 2'b00;
        end
        else
        begin
            tok_pipe <= {tok_issue, tok_pipe[1]};
        end
    end

    // Valid bits move through the pin register one stage per cycle
    always_ff @(posedge CLK or posedge rst_in)
    begin
        if (rst_in)
        begin
            pipe_vld <= 2'b00;
        end
        else
        begin
            pipe_vld <= {pinx_vld, pipe_vld[1]};
        end
    end

    // Data lanes move through the same two stages as the valid bits
    always_ff @(posedge CLK)
    begin
        pipe_data[1] <= pinx_data;
        pipe_data[0] <= pipe_data[1];
    end

    // The credit scheme keeps the FIFO from filling, so its write ready is not needed
    pinx_fifo pinx_fifo_inst
    (
        .CLK      (CLK),
        .rst_in   (rst_in),
        .din      (pipe_data[0]),
        .din_vld  (pipe_vld[0]),
        .din_rdy  (),
        .dout     (out_data),
        .dout_vld (out_vld),
        .dout_rdy (out_rdy)
    );

endmodule

/* verilog/pinx_loopback_top.sv */
`timescale 1ns/10ps

`include "pinx_cfg.svh"

module pinx_loopback_top
    import pinx_pkg::*;
(
    input  logic      CLK,
    input  logic      rst_in,

    // Words entering the link
    input  bus_word_t in_data,
    input  logic      in_vld,
    output logic      in_rdy,

    // Words leaving the link
    output bus_word_t out_data,
    output logic      out_vld,
    input  logic      out_rdy
);

    // Signals that would normally run across the board between two devices
    bus_word_t pinx_data;
    logic      pinx_vld;
    logic      pinx_tok;

    // Transmit end, spends credits and drives data onto the pins
    pinx_out pinx_out_inst
    (
        .CLK       (CLK),
        .rst_in    (rst_in),
        .in_data   (in_data),
        .in_vld    (in_vld),
        .in_rdy    (in_rdy),
        .pinx_data (pinx_data),
        .pinx_vld  (pinx_vld),
        .pinx_tok  (pinx_tok)
    );

    // Receive end, buffers the words and sends tokens back
    pinx_in pinx_in_inst
    (
        .CLK       (CLK),
        .rst_in    (rst_in),
        .pinx_data (pinx_data),
        .pinx_vld  (pinx_vld),
        .pinx_tok  (pinx_tok),
        .out_data  (out_data),
        .out_vld   (out_vld),
        .out_rdy   (out_rdy)
    );

endmodule

/* verilog/pinx_out.sv */
`timescale 1ns/10ps

`include "pinx_cfg.svh"

module pinx_out
    import pinx_pkg::*;
(
    input  logic      CLK,
    input  logic      rst_in,

    // Bus words arriving from the sending logic
    input  bus_word_t in_data,
    input  logic      in_vld,
    output logic      in_rdy,

    // Pin side of the link
    output bus_word_t pinx_data,
    output logic      pinx_vld,
    input  logic      pinx_tok
);

    // Credits still available, one per free receive slot
    credit_cnt_t credit_cnt;

    // Token from the pins after one register stage
    logic tok_q;

    // High on an edge where a bus word is taken and sent
    logic accept;

    // A word may only be taken while at least one credit is held
    // This is a plain decode of the counter register, so in_rdy has no
    // path from in_vld
    assign in_rdy = (credit_cnt != '0);
    assign accept = in_vld && in_rdy;

    // The token comes straight off a pin, so it goes through a flop first
    always_ff @(posedge CLK or posedge rst_in)
    begin
        if (rst_in)
        begin
            tok_q <= 1'b0;
        end
        else
        begin
            tok_q <= pinx_tok;
        end
    end

    // Each send spends a credit and each registered token gives one back
    // When both happen together the count stays where it is
    always_ff @(posedge CLK or posedge rst_in)
    begin
        if (rst_in)
        begin
            credit_cnt <= credit_cnt_t'(`PINX_RX_SLOTS);
        end
        else
        begin
            case ({accept, tok_q})
                2'b10:   credit_cnt <= credit_cnt - credit_cnt_t'(1);
                2'b01:   credit_cnt <= credit_cnt + credit_cnt_t'(1);
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    // Strobe on the pins for exactly one cycle per accepted word
    always_ff @(posedge CLK or posedge rst_in)
    begin
        if (rst_in)
        begin
            pinx_vld <= 1'b0;
        end
        else
        begin
            pinx_vld <= accept;
        end
    end

    // Pin data is only loaded on a send, otherwise the lanes keep their last value
    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            pinx_data <= in_data;
        end
    end

endmodule

/* verilog/pinx_pkg.sv */
`include "pinx_cfg.svh"

package pinx_pkg;

    // One word of the wide bus
    // The same type is used on the input bus, on the pins and on the output bus
    typedef logic [`PINX_BUS_WIDTH-1:0] bus_word_t;

    // Bits needed to count from zero up to the full slot limit
    // With 15 slots this comes out at 4 bits
    localparam int CREDIT_W = $clog2(`PINX_RX_SLOTS + 1);

    // Credit count on the transmit side and slot count on the receive side
    // Both range over 0 to PINX_RX_SLOTS, so they share one type
    typedef logic [CREDIT_W-1:0] credit_cnt_t;

endpackage
